//--- colmix_top.f
colmix_pkg.sv
prio_lookup.sv
pal_bank.sv
video_out.sv
colmix_top.sv
colmix_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the colour mixer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module colmix_tb \
    -f colmix_top.f \
    -o colmix_sim

# a fatal stop gives a nonzero status, the search below decides
output=$(./obj_dir/colmix_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    echo "simulation did not pass" >&2
    exit 1
fi

//--- colmix_testdata.txt
# P prom_addr layer | G addr word dsn | B addr blue | R cs addr expected_word
# X ba0 obj ba1 ba2 prisel gfx_en expected_rgb, every field in hex
# priority PROM entries for the pixel sets below
P 025 1
P 125 0
P 035 2
P 075 3
P 0ce 3
P 380 0
# red/green words, dsn 0 writes both bytes
G 185 a53c 0
G 012 1122 0
G 209 c0de 0
G 330 4455 0
G 3f7 9876 0
G 14a 2468 0
G 05f ffee 0
# blue bytes
B 185 7e
B 012 33
B 209 5a
B 330 66
B 3f7 10
B 14a ac
B 05f dd
# full word read-back
R 1 185 a53c
R 1 209 c0de
R 1 05f ffee
R 1 14a 2468
R 2 185 ff7e
R 2 012 ff33
R 2 3f7 ff10
# low byte only, high byte kept
G 185 7777 2
R 1 185 a577
# high byte only, low byte kept
G 185 5a00 1
R 1 185 5a77
R 2 185 ff7e
# all layers on, mode 0, sprite wins
X 12 85 09 30 0 f 775a7e
# same pixels in mode 2, ba0 wins
X 12 85 09 30 2 f 221133
# sprite layer off, entry 035 picks ba1
X 12 85 09 30 0 7 dec05a
# ba0 and sprites off, entry 075 picks ba2
X 12 85 09 30 0 6 554466
# back to all on
X 12 85 09 30 0 f 775a7e
# ba1 clear through bits 2:0 only, mode 1
X 00 4a 88 f7 1 f 769810
# same entry now hands the pixel to sprites
P 0ce 1
X 00 4a 88 f7 1 f 6824ac
# every layer opaque, mode 7
X 5f 07 01 0c 7 f eeffdd
# palette change shows through without a pixel change
G 05f 0102 0
B 05f 03
X 5f 07 01 0c 7 f 020103
R 1 05f 0102
R 2 05f ff03

//--- colmix_tb.sv
`timescale 1ns/1ps

module colmix_tb;

    // pixel steps the inputs stay put before a colour check
    localparam int hold_pulses   = 10;
    // clock cycles allowed for any single wait
    localparam int cycle_timeout = 400;

    logic                          clk;
    logic                          rst_n;
    logic                          pxl_cen;
    colmix_pkg::blank_t            blank_in;
    colmix_pkg::cpu_bus_t          cpu;
    logic [2:0]                    prisel;
    logic [3:0]                    gfx_en;
    logic [colmix_pkg::pal_aw-1:0] prog_addr;
    logic [1:0]                    prom_din;
    logic                          prom_we;
    colmix_pkg::layer_pxls_t       pxls;
    logic [colmix_pkg::cpu_dw-1:0] cpu_din;
    colmix_pkg::rgb_t              rgb;
    colmix_pkg::blank_t            blank_out;

    // reference copy of the PROM and both palette banks
    logic [1:0]  prom_model [colmix_pkg::pal_depth];
    logic [15:0] gr_model   [colmix_pkg::pal_depth];
    logic [7:0]  b_model    [colmix_pkg::pal_depth];
    // which entries the data file has written, gr per byte lane
    logic        prom_known [colmix_pkg::pal_depth];
    logic [1:0]  gr_known   [colmix_pkg::pal_depth];
    logic        b_known    [colmix_pkg::pal_depth];

    logic               cen_run;
    logic               monitor_on;
    int                 pulse_count;
    int                 checks_done;
    // blank_in at the last few enable pulses, oldest first
    colmix_pkg::blank_t blank_seen [$];

    colmix_top colmix_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .blank_in  (blank_in),
        .cpu       (cpu),
        .prisel    (prisel),
        .gfx_en    (gfx_en),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .pxls      (pxls),
        .cpu_din   (cpu_din),
        .rgb       (rgb),
        .blank_out (blank_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] next_rand(logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // PROM address from transparency and priority bits
    function automatic logic [9:0] prio_address(colmix_pkg::layer_pxls_t p,
                                                logic [2:0] mode, logic [3:0] en);
        logic [9:0] a;
        a[9:7] = mode;
        a[6]   = (p.ba0[3:0] == 4'h0) || !en[0];
        a[5]   = p.obj[7];
        a[4]   = (p.obj[3:0] == 4'h0) || !en[3];
        a[3]   = p.ba1[7];
        a[2]   = p.ba1[3];
        a[1]   = (p.ba1[2:0] == 3'h0) || !en[1];
        a[0]   = (p.ba2[3:0] == 4'h0) || !en[2];
        return a;
    endfunction

    // layer number on top, that layer's pixel below
    function automatic logic [9:0] palette_address(colmix_pkg::layer_pxls_t p,
                                                   logic [1:0] layer);
        logic [7:0] pix;
        case (layer)
            2'd0:    pix = p.ba0;
            2'd1:    pix = p.obj;
            2'd2:    pix = p.ba1;
            default: pix = p.ba2;
        endcase
        return {layer, pix};
    endfunction

    task automatic check_fields(int got, int want);
        if (got != want) begin
            stop_with_failure("malformed line in colmix_testdata.txt");
        end
    endtask

    // counts enable pulses seen by the DUT, sampled between edges
    task automatic wait_pulses(int n);
        int start;
        int cycles;
        @(negedge clk);
        start  = pulse_count;
        cycles = 0;
        while (pulse_count - start < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > cycle_timeout) begin
                stop_with_failure("timed out waiting for pixel clock enable pulses");
            end
        end
    endtask

    task automatic write_prom(logic [9:0] waddr, logic [1:0] wdata);
        prom_model[waddr] = wdata;
        prom_known[waddr] = 1'b1;
        @(posedge clk);
        prog_addr <= waddr;
        prom_din  <= wdata;
        prom_we   <= 1'b1;
        @(posedge clk);
        prom_we   <= 1'b0;
    endtask

    // active low byte strobes
    task automatic write_gr(logic [9:0] waddr, logic [15:0] wdata, logic [1:0] dsn);
        if (!dsn[0]) begin
            gr_model[waddr][7:0] = wdata[7:0];
            gr_known[waddr][0]   = 1'b1;
        end
        if (!dsn[1]) begin
            gr_model[waddr][15:8] = wdata[15:8];
            gr_known[waddr][1]    = 1'b1;
        end
        @(posedge clk);
        cpu <= '{addr: waddr, dout: wdata, dsn: dsn, pal_cs: 2'b01};
        @(posedge clk);
        cpu.dsn    <= 2'b11;
        cpu.pal_cs <= 2'b00;
    endtask

    // blue rides the low byte lane
    task automatic write_blue(logic [9:0] waddr, logic [7:0] wdata);
        b_model[waddr] = wdata;
        b_known[waddr] = 1'b1;
        @(posedge clk);
        cpu <= '{addr: waddr, dout: {8'h00, wdata}, dsn: 2'b10, pal_cs: 2'b10};
        @(posedge clk);
        cpu.dsn    <= 2'b11;
        cpu.pal_cs <= 2'b00;
    endtask

    task automatic read_cpu(logic [1:0] cs, logic [9:0] raddr, logic [15:0] file_val);
        logic [15:0] want;
        logic [15:0] got;
        if (cs == 2'b01) begin
            if (gr_known[raddr] != 2'b11) begin
                stop_with_failure("test data reads a red/green word never written");
            end
            want = gr_model[raddr];
        end else begin
            if (!b_known[raddr]) begin
                stop_with_failure("test data reads a blue byte never written");
            end
            want = {8'hff, b_model[raddr]};
        end
        assert (want == file_val) else stop_with_failure($sformatf(
            "[FAIL] at %0t: file expects %04h at %03h, model holds %04h",
            $time, file_val, raddr, want));
        @(posedge clk);
        cpu <= '{addr: raddr, dout: 16'h0000, dsn: 2'b11, pal_cs: cs};
        // one cycle registered read
        @(posedge clk);
        @(negedge clk);
        got = cpu_din;
        assert (got == want) else stop_with_failure($sformatf(
            "[FAIL] at %0t: cpu read cs %0d addr %03h gave %04h, expected %04h",
            $time, cs, raddr, got, want));
        checks_done++;
        @(posedge clk);
        cpu.pal_cs <= 2'b00;
    endtask

    task automatic check_pixels(colmix_pkg::layer_pxls_t p, logic [2:0] mode,
                                logic [3:0] en, colmix_pkg::rgb_t file_rgb);
        logic [9:0]       pr_addr;
        logic [9:0]       pa;
        colmix_pkg::rgb_t want;
        pr_addr = prio_address(p, mode, en);
        if (!prom_known[pr_addr]) begin
            stop_with_failure("test data uses a priority PROM entry never written");
        end
        pa = palette_address(p, prom_model[pr_addr]);
        if (gr_known[pa] != 2'b11 || !b_known[pa]) begin
            stop_with_failure("test data uses a palette entry never written");
        end
        // red low byte, green high byte of the gr word
        want = {gr_model[pa][7:0], gr_model[pa][15:8], b_model[pa]};
        assert (want == file_rgb) else stop_with_failure($sformatf(
            "[FAIL] at %0t: file expects rgb %06h, model gives %06h",
            $time, file_rgb, want));
        @(posedge clk);
        pxls   <= p;
        prisel <= mode;
        gfx_en <= en;
        wait_pulses(hold_pulses);
        assert (rgb == want) else stop_with_failure($sformatf(
            "[FAIL] at %0t: pixels %08h mode %0d en %h gave rgb %06h, expected %06h",
            $time, p, mode, en, rgb, want));
        checks_done++;
    endtask

    // random enable pulses and blanks, plus the record of what the DUT took
    initial begin
        logic [31:0] rnd;
        rnd         = 32'h6486d593;
        pxl_cen     = 1'b0;
        blank_in    = '0;
        pulse_count = 0;
        forever begin
            @(posedge clk);
            if (rst_n && pxl_cen) begin
                pulse_count <= pulse_count + 1;
                blank_seen.push_back(blank_in);
                if (blank_seen.size() > colmix_pkg::blank_dly) begin
                    void'(blank_seen.pop_front());
                end
            end
            if (cen_run) begin
                rnd = next_rand(rnd);
                pxl_cen  <= rnd[0];
                blank_in <= rnd[9:8];
            end
        end
    end

    // blanks leave blank_dly pulses after they went in, zero before that
    always @(negedge clk) begin : blank_check
        colmix_pkg::blank_t want;
        if (monitor_on) begin
            if (blank_seen.size() == colmix_pkg::blank_dly) begin
                want = blank_seen[0];
            end else begin
                want = '0;
            end
            assert (blank_out == want) else stop_with_failure($sformatf(
                "[FAIL] at %0t: blank_out %b, expected %b", $time, blank_out, want));
        end
    end

    initial begin
        int          fd;
        int          code;
        int          c;
        logic [7:0]  op;
        logic [31:0] f1, f2, f3, f4, f5, f6, f7;
        rst_n       = 1'b0;
        cpu         = '{addr: '0, dout: '0, dsn: 2'b11, pal_cs: 2'b00};
        prisel      = '0;
        gfx_en      = '0;
        prog_addr   = '0;
        prom_din    = '0;
        prom_we     = 1'b0;
        pxls        = '0;
        cen_run     = 1'b0;
        monitor_on  = 1'b0;
        checks_done = 0;
        for (int i = 0; i < colmix_pkg::pal_depth; i++) begin
            prom_known[i] = 1'b0;
            gr_known[i]   = 2'b00;
            b_known[i]    = 1'b0;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // no enable pulse yet, output still black and blanked
        @(negedge clk);
        assert (rgb == '0 && blank_out == '0) else stop_with_failure($sformatf(
            "[FAIL] at %0t: after reset rgb %06h blank_out %b", $time, rgb, blank_out));
        checks_done++;
        monitor_on = 1'b1;
        cen_run    = 1'b1;

        fd = $fopen("colmix_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open colmix_testdata.txt");
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (op == "P") begin
                check_fields($fscanf(fd, "%h %h", f1, f2), 2);
                write_prom(f1[9:0], f2[1:0]);
            end else if (op == "G") begin
                check_fields($fscanf(fd, "%h %h %h", f1, f2, f3), 3);
                write_gr(f1[9:0], f2[15:0], f3[1:0]);
            end else if (op == "B") begin
                check_fields($fscanf(fd, "%h %h", f1, f2), 2);
                write_blue(f1[9:0], f2[7:0]);
            end else if (op == "R") begin
                check_fields($fscanf(fd, "%h %h %h", f1, f2, f3), 3);
                read_cpu(f1[1:0], f2[9:0], f3[15:0]);
            end else if (op == "X") begin
                check_fields($fscanf(fd, "%h %h %h %h %h %h %h",
                                     f1, f2, f3, f4, f5, f6, f7), 7);
                check_pixels('{ba0: f1[7:0], obj: f2[7:0], ba1: f3[7:0], ba2: f4[7:0]},
                             f5[2:0], f6[3:0], f7[23:0]);
            end else begin
                stop_with_failure($sformatf("unknown operation '%c' in colmix_testdata.txt",
                                            op));
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        if (checks_done > 1) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_with_failure("colmix_testdata.txt held no checks");
        end
    end

endmodule

//--- colmix_top.sv
`timescale 1ns/1ps

module colmix_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pxl_cen,
    input  colmix_pkg::blank_t              blank_in,
    input  colmix_pkg::cpu_bus_t            cpu,
    input  logic [2:0]                      prisel,
    input  logic [3:0]                      gfx_en,
    input  logic [colmix_pkg::pal_aw-1:0]   prog_addr,
    input  logic [1:0]                      prom_din,
    input  logic                            prom_we,
    input  colmix_pkg::layer_pxls_t         pxls,
    output logic [colmix_pkg::cpu_dw-1:0]   cpu_din,
    output colmix_pkg::rgb_t                rgb,
    output colmix_pkg::blank_t              blank_out
);

    logic [colmix_pkg::pal_aw-1:0] pal_addr;
    logic [1:0]                    we_gr;
    logic                          we_b;
    logic [colmix_pkg::cpu_dw-1:0] cpu_gr;
    logic [colmix_pkg::cpu_dw-1:0] cpu_b;
    logic [colmix_pkg::cpu_dw-1:0] vid_gr;
    logic [colmix_pkg::cpu_dw-1:0] vid_b;

    // byte strobes active low on the bus
    assign we_gr = ~cpu.dsn & {2{cpu.pal_cs[0]}};
    // blue lives on the low byte lane
    assign we_b  = ~cpu.dsn[0] & cpu.pal_cs[1];

    // blue reads back with the upper byte floating high
    assign cpu_din = cpu.pal_cs[0] ? cpu_gr : {8'hff, cpu_b[7:0]};

    prio_lookup u_prio (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pxls      (pxls),
        .prisel    (prisel),
        .gfx_en    (gfx_en),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .pal_addr  (pal_addr)
    );

    // green high byte, red low byte
    pal_bank #(.bytes(2)) u_bank_gr (
        .clk      (clk),
        .cpu_addr (cpu.addr),
        .cpu_data (cpu.dout),
        .cpu_we   (we_gr),
        .vid_addr (pal_addr),
        .cpu_q    (cpu_gr),
        .vid_q    (vid_gr)
    );

    pal_bank #(.bytes(1)) u_bank_b (
        .clk      (clk),
        .cpu_addr (cpu.addr),
        .cpu_data (cpu.dout),
        .cpu_we   (we_b),
        .vid_addr (pal_addr),
        .cpu_q    (cpu_b),
        .vid_q    (vid_b)
    );

    video_out u_video (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .gr        (vid_gr),
        .b         (vid_b[7:0]),
        .blank_in  (blank_in),
        .rgb       (rgb),
        .blank_out (blank_out)
    );

    // one bank per access, read-back mux assumes it
    a_one_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(&cpu.pal_cs)
    );

endmodule

//--- video_out.sv
`timescale 1ns/1ps

module video_out (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  logic [15:0]             gr,
    input  logic [7:0]              b,
    input  colmix_pkg::blank_t      blank_in,
    output colmix_pkg::rgb_t        rgb,
    output colmix_pkg::blank_t      blank_out
);

    colmix_pkg::rgb_t   rgb_in;
    colmix_pkg::rgb_t   rgb_line   [colmix_pkg::blank_dly];
    colmix_pkg::blank_t blank_line [colmix_pkg::blank_dly];

    // red in the low byte, green in the high byte
    assign rgb_in = '{
        red:   gr[7:0],
        green: gr[15:8],
        blue:  b
    };

    // colour and blanks share the same depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < colmix_pkg::blank_dly; i++) begin
                rgb_line[i]   <= '0;
                blank_line[i] <= '0;
            end
        end else if (pxl_cen) begin
            rgb_line[0]   <= rgb_in;
            blank_line[0] <= blank_in;
            for (int i = 1; i < colmix_pkg::blank_dly; i++) begin
                rgb_line[i]   <= rgb_line[i-1];
                blank_line[i] <= blank_line[i-1];
            end
        end
    end

    // last stage drives the screen
    assign rgb       = rgb_line[colmix_pkg::blank_dly-1];
    assign blank_out = blank_line[colmix_pkg::blank_dly-1];

endmodule

//--- pal_bank.sv
`timescale 1ns/1ps

module pal_bank #(
    parameter int bytes = 2
) (
    input  logic                                clk,
    input  logic [colmix_pkg::pal_aw-1:0]       cpu_addr,
    input  logic [colmix_pkg::cpu_dw-1:0]       cpu_data,
    input  logic [bytes-1:0]                    cpu_we,
    input  logic [colmix_pkg::pal_aw-1:0]       vid_addr,
    output logic [colmix_pkg::cpu_dw-1:0]       cpu_q,
    output logic [colmix_pkg::cpu_dw-1:0]       vid_q
);

    // stored word width
    localparam int dw = bytes * 8;

    logic [dw-1:0] mem [colmix_pkg::pal_depth];
    logic [dw-1:0] cpu_q_r;
    logic [dw-1:0] vid_q_r;

    // cpu port, per byte write enables
    always_ff @(posedge clk) begin
        for (int i = 0; i < bytes; i++) begin
            if (cpu_we[i]) begin
                mem[cpu_addr][i*8 +: 8] <= cpu_data[i*8 +: 8];
            end
        end
        // read shows the word before this edge's write
        cpu_q_r <= mem[cpu_addr];
    end

    // video port, read only
    always_ff @(posedge clk) begin
        vid_q_r <= mem[vid_addr];
    end

    // narrow banks leave the upper byte zero
    generate
        if (bytes == 2) begin : g_wide
            assign cpu_q = cpu_q_r;
            assign vid_q = vid_q_r;
        end else begin : g_narrow
            assign cpu_q = {{(colmix_pkg::cpu_dw - dw){1'b0}}, cpu_q_r};
            assign vid_q = {{(colmix_pkg::cpu_dw - dw){1'b0}}, vid_q_r};
        end
    endgenerate

    // strobes come from the cpu decode, never X once the bus runs
    a_we_known: assert property (
        @(posedge clk) !$isunknown(cpu_we)
    );

endmodule

//--- prio_lookup.sv
`timescale 1ns/1ps

module prio_lookup (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pxl_cen,
    input  colmix_pkg::layer_pxls_t        pxls,
    input  logic [2:0]                     prisel,
    input  logic [3:0]                     gfx_en,
    input  logic [colmix_pkg::pal_aw-1:0]  prog_addr,
    input  logic [1:0]                     prom_din,
    input  logic                           prom_we,
    output logic [colmix_pkg::pal_aw-1:0]  pal_addr
);

    // writable priority PROM, loaded by the cpu or the boot loader
    logic [1:0] prom [colmix_pkg::pal_depth];

    logic [colmix_pkg::pal_aw-1:0] prio_addr;
    colmix_pkg::layer_pxls_t       pxls_q;
    colmix_pkg::layer_pxls_t       pxls_s;
    colmix_pkg::layer_sel_t        sel;
    logic [colmix_pkg::pxl_w-1:0]  win_pxl;

    // priority address, one stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_addr <= '0;
            pxls_q    <= '0;
        end else begin
            prio_addr <= {
                prisel,
                // ba0 clear: low nibble empty or layer off
                ~|pxls.ba0[3:0] | ~gfx_en[0],
                pxls.obj[7],
                // sprites clear
                ~|pxls.obj[3:0] | ~gfx_en[3],
                pxls.ba1[7],
                pxls.ba1[3],
                // ba1 only looks at three bits for transparency
                ~|pxls.ba1[2:0] | ~gfx_en[1],
                ~|pxls.ba2[3:0] | ~gfx_en[2]
            };
            // pixels follow the address register
            pxls_q    <= pxls;
        end
    end

    // PROM write port
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= prom_din;
        end
    end

    // registered PROM read, every cycle
    // pixels take the same step so they match the winner
    always_ff @(posedge clk) begin
        sel    <= colmix_pkg::layer_sel_t'(prom[prio_addr]);
        pxls_s <= pxls_q;
    end

    // pick the winning pixel
    always_comb begin
        case (sel)
            colmix_pkg::sel_ba0: win_pxl = pxls_s.ba0;
            colmix_pkg::sel_obj: win_pxl = pxls_s.obj;
            colmix_pkg::sel_ba1: win_pxl = pxls_s.ba1;
            default:             win_pxl = pxls_s.ba2;
        endcase
    end

    // layer number on top selects the palette quarter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= {sel, win_pxl};
        end
    end

    // a PROM write must land on a known entry
    a_prom_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        prom_we |-> !$isunknown(prog_addr)
    );

endmodule

//--- colmix_pkg.sv
package colmix_pkg;

    // one layer pixel, palette index within a layer
    localparam int pxl_w = 8;
    // palette and priority PROM address width
    localparam int pal_aw = 10;
    // entries in each palette bank and in the PROM
    localparam int pal_depth = 1 << pal_aw;
    // cpu data bus width
    localparam int cpu_dw = 16;
    // one colour component
    localparam int col_w = 8;
    // pixel steps from the priority address to colour out
    localparam int blank_dly = 2;

    // layer pixels as the tile and sprite engines hand them over
    // ba0 sits in the top byte
    typedef struct packed {
        logic [pxl_w-1:0] ba0;
        logic [pxl_w-1:0] obj;
        logic [pxl_w-1:0] ba1;
        logic [pxl_w-1:0] ba2;
    } layer_pxls_t;

    // priority PROM word, also the palette bank number
    typedef enum logic [1:0] {
        sel_ba0 = 2'd0,
        sel_obj = 2'd1,
        sel_ba1 = 2'd2,
        sel_ba2 = 2'd3
    } layer_sel_t;

    typedef struct packed {
        logic [col_w-1:0] red;
        logic [col_w-1:0] green;
        logic [col_w-1:0] blue;
    } rgb_t;

    // both low while blanking
    typedef struct packed {
        logic hb;
        logic vb;
    } blank_t;

    // cpu side of the palette, strobes active as named
    typedef struct packed {
        logic [pal_aw-1:0] addr;
        logic [cpu_dw-1:0] dout;
        logic [1:0]        dsn;
        logic [1:0]        pal_cs;
    } cpu_bus_t;

endpackage
